// File: cam_search.f
+incdir+logic
logic/cam_search_pkg.sv
logic/cam_bus_port.sv
logic/cam_match_pipe.sv
logic/cam_result_fifo.sv
logic/cam_search_top.sv
tb/cam_search_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
    -f cam_search.f \
    --top-module cam_search_tb \
    -o cam_search_sim

output=$(./obj_dir/cam_search_sim)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb/cam_search_tb.sv
`timescale 1ns/1ps
`include "cam_search_macros.svh"

module cam_search_tb import cam_search_pkg::*; ();

    localparam int TIMEOUT = 50;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     wb_err;

    // Mirror of the entry table
    cam_key_t model [`CAM_DEPTH];
    bit       used [256];
    // Expected read words, oldest search first
    wb_data_t expected_q [$];
    wb_data_t rdata;
    logic     acked;
    logic     erred;
    int       checks;
    int       errors;

    cam_search_top i_cam_search_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic end_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_word(input string what, input wb_data_t got, input wb_data_t exp);
        checks++;
        assert (got == exp) else begin
            $display("Fail at time %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_answer(input wb_addr_t adr, input logic exp_err);
        checks++;
        assert (acked == !exp_err && erred == exp_err) else begin
            $display("Fail at time %0t: address %0d answered ack=%b err=%b",
                     $time, adr, acked, erred);
            errors++;
        end
    endtask

    // One classic cycle with the request held past the answer edge
    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t data,
                              input logic exp_err);
        int waited;
        waited = 0;
        acked = 1'b0;
        erred = 1'b0;
        rdata = '0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        while (!acked && !erred && waited < TIMEOUT) begin
            @(negedge clk);
            acked = wb_ack;
            erred = wb_err;
            rdata = wb_dat_r;
            waited++;
        end
        if (!acked && !erred) begin
            $display("Timeout at time %0t: no bus response at address %0d", $time, adr);
            errors++;
            end_run();
        end else begin
            @(negedge clk);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            check_answer(adr, exp_err);
        end
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t data, input logic exp_err);
        bus_access(1'b1, adr, data, exp_err);
    endtask

    task automatic bus_read(input wb_addr_t adr);
        bus_access(1'b0, adr, '0, 1'b0);
    endtask

    // Highest matching index wins
    function automatic wb_data_t predict(input cam_key_t key);
        for (int i = `CAM_DEPTH - 1; i >= 0; i--) begin
            if (model[i] == key) begin
                return 32'h300 | wb_data_t'(i);
            end
        end
        return 32'h200;
    endfunction

    function automatic cam_key_t pick_absent_key();
        cam_key_t key;
        do begin
            key = cam_key_t'($urandom);
        end while (predict(key) != 32'h200);
        return key;
    endfunction

    task automatic write_entry(input int idx, input cam_key_t key);
        bus_write(wb_addr_t'(idx), {24'd0, key}, 1'b0);
        model[idx] = key;
    endtask

    task automatic search(input cam_key_t key, input logic exp_err);
        bus_write(wb_addr_t'(`CAM_ADR_KEY), {24'd0, key}, exp_err);
        if (!exp_err) begin
            expected_q.push_back(predict(key));
        end
    endtask

    // Poll status until n results sit in the queue and pop them
    task automatic drain(input int n);
        int waited;
        waited = 0;
        bus_read(wb_addr_t'(`CAM_ADR_STATUS));
        while (rdata != wb_data_t'(n) && waited < TIMEOUT) begin
            bus_read(wb_addr_t'(`CAM_ADR_STATUS));
            waited++;
        end
        if (rdata != wb_data_t'(n)) begin
            $display("Timeout at time %0t: queue never held %0d results", $time, n);
            errors++;
            end_run();
        end else begin
            repeat (n) begin
                bus_read(wb_addr_t'(`CAM_ADR_RESULT));
                check_word("result pop", rdata, expected_q.pop_front());
            end
        end
    endtask

    initial begin
        cam_key_t    key;
        cam_key_t    dup;
        int unsigned seed;
        seed = 32'h9674_609f;
        void'($urandom(seed));
        checks   = 0;
        errors   = 0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Cleared table and empty queue
        bus_read(wb_addr_t'(`CAM_ADR_STATUS));
        check_word("status after reset", rdata, '0);
        bus_read(wb_addr_t'(`CAM_ADR_RESULT));
        check_word("empty queue read", rdata, '0);
        search(8'h00, 1'b0);
        drain(1);

        // Distinct keys in every entry and searches in groups of four
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            do begin
                key = cam_key_t'($urandom);
            end while (used[key]);
            used[key] = 1'b1;
            write_entry(i, key);
        end
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            search(model[i], 1'b0);
            if (i % 4 == 3) begin
                drain(4);
            end
        end

        // Duplicate key in entries 3 and 11
        dup = model[3];
        write_entry(11, dup);
        search(dup, 1'b0);
        drain(1);
        write_entry(11, pick_absent_key());
        search(dup, 1'b0);
        drain(1);

        // Miss
        search(pick_absent_key(), 1'b0);
        drain(1);

        // Fill every reserved slot so the fifth search is refused
        for (int i = 0; i < `CAM_QUEUE_DEPTH; i++) begin
            search(model[i * 4 + 1], 1'b0);
        end
        search(model[0], 1'b1);
        drain(4);
        search(model[7], 1'b0);
        drain(1);

        // Unmapped addresses
        key = pick_absent_key();
        bus_write(wb_addr_t'(20), {24'd0, key}, 1'b0);
        bus_read(wb_addr_t'(25));
        check_word("unmapped read", rdata, '0);
        search(key, 1'b0);
        drain(1);
        search(model[5], 1'b0);
        drain(1);

        end_run();
    end

endmodule

// File: logic/cam_search_top.sv
`timescale 1ns/1ps

module cam_search_top import cam_search_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output logic     wb_err
);

    cam_write_t  entry_wr;
    logic        entry_wr_valid;
    cam_key_t    search_key;
    logic        search_valid;
    cam_result_t result;
    logic        result_valid;
    logic        pop;
    cam_result_t head;
    logic        not_empty;
    logic [2:0]  count;
    logic        slot_free;

    // Bus side
    cam_bus_port i_cam_bus_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .wb_err         (wb_err),
        .entry_wr       (entry_wr),
        .entry_wr_valid (entry_wr_valid),
        .search_key     (search_key),
        .search_valid   (search_valid),
        .pop            (pop),
        .head           (head),
        .not_empty      (not_empty),
        .count          (count),
        .slot_free      (slot_free)
    );

    cam_match_pipe i_cam_match_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .entry_wr       (entry_wr),
        .entry_wr_valid (entry_wr_valid),
        .search_key     (search_key),
        .search_valid   (search_valid),
        .result         (result),
        .result_valid   (result_valid)
    );

    // Result side
    cam_result_fifo i_cam_result_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .result         (result),
        .result_valid   (result_valid),
        .search_valid   (search_valid),
        .pop            (pop),
        .head           (head),
        .not_empty      (not_empty),
        .count          (count),
        .slot_free      (slot_free)
    );

endmodule

// File: logic/cam_result_fifo.sv
`timescale 1ns/1ps
`include "cam_search_macros.svh"

module cam_result_fifo import cam_search_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cam_result_t result,
    input  logic        result_valid,
    input  logic        search_valid,
    input  logic        pop,
    output cam_result_t head,
    output logic        not_empty,
    output logic [2:0]  count,
    output logic        slot_free
);

    localparam int PTR_W = $clog2(`CAM_QUEUE_DEPTH);

    cam_result_t        slots [`CAM_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    // Searches holding a slot, in flight or stored
    logic [2:0]         reserved;
    logic               do_pop;

    assign do_pop    = pop && not_empty;
    assign head      = slots[rd_ptr];
    assign not_empty = count != 3'd0;
    assign slot_free = reserved < 3'(`CAM_QUEUE_DEPTH);

    always_ff @(posedge clk) begin
        if (result_valid) begin
            slots[wr_ptr] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            reserved <= '0;
        end else begin
            if (result_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CAM_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CAM_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + {2'd0, result_valid} - {2'd0, do_pop};
            reserved <= reserved + {2'd0, search_valid} - {2'd0, do_pop};
        end
    end

endmodule

// File: logic/cam_match_pipe.sv
`timescale 1ns/1ps
`include "cam_search_macros.svh"

module cam_match_pipe import cam_search_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cam_write_t  entry_wr,
    input  logic        entry_wr_valid,
    input  cam_key_t    search_key,
    input  logic        search_valid,
    output cam_result_t result,
    output logic        result_valid
);

    cam_key_t                entries [`CAM_DEPTH];

    // Stage one, compare
    logic [`CAM_DEPTH-1:0]   s1_hits;
    logic                    s1_valid;

    // Stage two, encode
    cam_result_t             s2_result;
    logic                    s2_valid;

    cam_result_t             encoded;

    // Entry table, cleared to all zero keys
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CAM_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (entry_wr_valid) begin
            entries[entry_wr.index] <= entry_wr.key;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            s1_hits[i] <= (entries[i] == search_key);
        end
    end

    // Later hits overwrite earlier ones, so the highest index wins
    always_comb begin
        encoded = '0;
        for (int i = 0; i < `CAM_DEPTH; i++) begin
            if (s1_hits[i]) begin
                encoded.hit   = 1'b1;
                encoded.index = cam_index_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        s2_result <= encoded;
        result    <= s2_result;
    end

    // Valid bits walk alongside the payload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= search_valid;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

endmodule

// File: logic/cam_bus_port.sv
`timescale 1ns/1ps
`include "cam_search_macros.svh"

module cam_bus_port import cam_search_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_addr_t    wb_adr,
    input  wb_data_t    wb_dat_w,
    output wb_data_t    wb_dat_r,
    output logic        wb_ack,
    output logic        wb_err,
    output cam_write_t  entry_wr,
    output logic        entry_wr_valid,
    output cam_key_t    search_key,
    output logic        search_valid,
    output logic        pop,
    input  cam_result_t head,
    input  logic        not_empty,
    input  logic [2:0]  count,
    input  logic        slot_free
);

    bus_state_t state;

    // Request captured in bus_idle
    wb_addr_t   req_adr;
    logic       req_we;
    cam_key_t   req_key;

    logic       bus_req;
    logic       answering;
    logic       is_entry;
    logic       is_key;
    logic       is_result;
    logic       is_status;
    logic       refuse;

    assign bus_req   = wb_cyc && wb_stb;
    // Answer only while the master still holds the cycle
    assign answering = (state == bus_respond) && bus_req;

    assign is_entry  = req_adr < wb_addr_t'(`CAM_DEPTH);
    assign is_key    = req_adr == wb_addr_t'(`CAM_ADR_KEY);
    assign is_result = req_adr == wb_addr_t'(`CAM_ADR_RESULT);
    assign is_status = req_adr == wb_addr_t'(`CAM_ADR_STATUS);

    // No reserved room left for another search
    assign refuse    = req_we && is_key && !slot_free;

    assign wb_ack = answering && !refuse;
    assign wb_err = answering && refuse;

    always_comb begin
        wb_dat_r = '0;
        if (state == bus_respond && !req_we) begin
            if (is_result && not_empty) begin
                wb_dat_r = {22'd0, not_empty, head.hit, 4'd0, head.index};
            end else if (is_status) begin
                wb_dat_r = {29'd0, count};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bus_idle;
        end else begin
            case (state)
                bus_idle:    if (bus_req) state <= bus_respond;
                bus_respond: state <= bus_idle;
                default:     state <= bus_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_idle && bus_req) begin
            req_adr <= wb_adr;
            req_we  <= wb_we;
            req_key <= wb_dat_w[`CAM_KEY_W-1:0];
        end
    end

    // Strobes fire on the answer edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_wr_valid <= 1'b0;
            search_valid   <= 1'b0;
            pop            <= 1'b0;
        end else begin
            entry_wr_valid <= answering && req_we && is_entry;
            search_valid   <= answering && req_we && is_key && slot_free;
            pop            <= answering && !req_we && is_result && not_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (answering) begin
            entry_wr.index <= cam_index_t'(req_adr);
            entry_wr.key   <= req_key;
            search_key     <= req_key;
        end
    end

endmodule

// File: logic/cam_search_pkg.sv
`include "cam_search_macros.svh"

package cam_search_pkg;

    typedef logic [`CAM_KEY_W-1:0]          cam_key_t;
    typedef logic [$clog2(`CAM_DEPTH)-1:0]  cam_index_t;
    typedef logic [4:0]                     wb_addr_t;
    typedef logic [31:0]                    wb_data_t;

    // Table write request
    typedef struct packed {
        cam_index_t index;
        cam_key_t   key;
    } cam_write_t;

    // One search outcome, index is zero on a miss
    typedef struct packed {
        logic       hit;
        cam_index_t index;
    } cam_result_t;

    typedef enum logic {
        bus_idle,
        bus_respond
    } bus_state_t;

endpackage

// File: logic/cam_search_macros.svh
`ifndef CAM_SEARCH_MACROS_SVH
`define CAM_SEARCH_MACROS_SVH

// Table and key geometry
`define CAM_KEY_W        8
`define CAM_DEPTH        16

// Result queue slots
`define CAM_QUEUE_DEPTH  4

// Word addresses above the entry window
`define CAM_ADR_KEY      16
`define CAM_ADR_RESULT   17
`define CAM_ADR_STATUS   18

`endif
